/* rtl/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Byte address of the processor bus.
`define CACHE_ADDR_WIDTH 16
`define CACHE_WORD_BITS 16

// Sixteen bytes per line, eight sets per way.
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 3
`define CACHE_LINE_BITS 128

`define CACHE_SETS (1 << `CACHE_INDEX_BITS)
`define CACHE_TAG_BITS (`CACHE_ADDR_WIDTH - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`endif

/* rtl/lc3b_mem_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package lc3b_mem_pkg;

	typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`CACHE_WORD_BITS-1:0] word_t;

	// One line is eight words, moved to and from memory as a unit.
	typedef logic [`CACHE_LINE_BITS-1:0] line_t;

	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;
	typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

	// Bit 0 enables the low byte of a word, bit 1 the high byte.
	typedef logic [1:0] byte_en_t;

endpackage : lc3b_mem_pkg

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	typedef enum logic [1:0] {
		st_hold,
		st_read_mem,
		st_write_mem,
		st_mem_break
	} cache_state_t;

	// Also the encoding of the LRU bit: it names the way to replace next.
	typedef enum logic {
		way_1 = 1'b0,
		way_2 = 1'b1
	} way_t;

endpackage : cache_pkg

`default_nettype wire

/* rtl/cache_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if
	import cache_pkg::*;
();

	logic load_data_1;
	logic load_data_2;
	logic load_dirty_1;
	logic load_dirty_2;
	logic dirty_in;
	logic cpu_src;
	logic load_lru;
	way_t lru_in;
	logic wb_addr;

	logic way1_hit;
	logic way2_hit;
	way_t lru_out;
	logic dirty_out;

	modport control (
		output load_data_1, load_data_2,
		output load_dirty_1, load_dirty_2, dirty_in,
		output cpu_src, load_lru, lru_in, wb_addr,
		input way1_hit, way2_hit, lru_out, dirty_out
	);

	modport datapath (
		input load_data_1, load_data_2,
		input load_dirty_1, load_dirty_2, dirty_in,
		input cpu_src, load_lru, lru_in, wb_addr,
		output way1_hit, way2_hit, lru_out, dirty_out
	);

endinterface : cache_ctrl_if

`default_nettype wire

/* rtl/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_control
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,

	input logic cpu_read,
	input logic cpu_write,
	input logic pmem_resp,

	output logic cpu_resp,
	output logic pmem_read,
	output logic pmem_write,

	cache_ctrl_if.control ctrl
);

	cache_state_t state;
	cache_state_t next_state;
	logic hit;

	assign hit = ctrl.way1_hit | ctrl.way2_hit;

	always_comb begin
		ctrl.load_data_1 = 1'b0;
		ctrl.load_data_2 = 1'b0;
		ctrl.load_dirty_1 = 1'b0;
		ctrl.load_dirty_2 = 1'b0;
		ctrl.dirty_in = 1'b0;
		ctrl.cpu_src = 1'b0;
		ctrl.load_lru = 1'b0;
		ctrl.lru_in = way_1;
		ctrl.wb_addr = 1'b0;
		cpu_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		case (state)
			st_hold: begin
				if (cpu_read && hit) begin
					ctrl.load_lru = 1'b1;
					ctrl.lru_in = ctrl.way1_hit ? way_2 : way_1;
					cpu_resp = 1'b1;
				end else if (cpu_write && hit) begin
					// Merge the CPU bytes into the hit way and mark it dirty.
					ctrl.cpu_src = 1'b1;
					ctrl.dirty_in = 1'b1;
					ctrl.load_lru = 1'b1;
					if (ctrl.way1_hit) begin
						ctrl.load_data_1 = 1'b1;
						ctrl.load_dirty_1 = 1'b1;
						ctrl.lru_in = way_2;
					end else begin
						ctrl.load_data_2 = 1'b1;
						ctrl.load_dirty_2 = 1'b1;
						ctrl.lru_in = way_1;
					end
					cpu_resp = 1'b1;
				end
			end

			st_read_mem: begin
				pmem_read = 1'b1;
				// The fill lands in the LRU way as a clean line.
				if (pmem_resp) begin
					if (ctrl.lru_out == way_1) begin
						ctrl.load_data_1 = 1'b1;
						ctrl.load_dirty_1 = 1'b1;
					end else begin
						ctrl.load_data_2 = 1'b1;
						ctrl.load_dirty_2 = 1'b1;
					end
				end
			end

			st_write_mem: begin
				pmem_write = 1'b1;
				ctrl.wb_addr = 1'b1;
			end

			st_mem_break: begin
				// One idle cycle to let memory drop its response.
			end

			default: begin
			end
		endcase
	end

	always_comb begin
		next_state = state;

		case (state)
			st_hold: begin
				if ((cpu_read || cpu_write) && !hit) begin
					next_state = ctrl.dirty_out ? st_write_mem : st_read_mem;
				end
			end

			st_read_mem: begin
				if (pmem_resp) begin
					next_state = st_hold;
				end
			end

			st_write_mem: begin
				if (pmem_resp) begin
					next_state = st_mem_break;
				end
			end

			st_mem_break: begin
				next_state = st_read_mem;
			end

			default: begin
				next_state = st_hold;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_hold;
		end else begin
			state <= next_state;
		end
	end

endmodule : cache_control

`default_nettype wire

/* rtl/cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_datapath
	import lc3b_mem_pkg::*;
	import cache_pkg::*;
(
	input logic clk,
	input logic reset,

	input addr_t cpu_address,
	input word_t cpu_wdata,
	input byte_en_t cpu_byte_enable,
	output word_t cpu_rdata,

	output addr_t pmem_address,
	input line_t pmem_rdata,
	output line_t pmem_wdata,

	cache_ctrl_if.datapath dp
);

	// Index 0 of the way dimension is way 1, index 1 is way 2.
	line_t data_arr [2][`CACHE_SETS];
	tag_t tag_arr [2][`CACHE_SETS];
	logic [1:0][`CACHE_SETS-1:0] valid_bits;
	logic [1:0][`CACHE_SETS-1:0] dirty_bits;
	logic [`CACHE_SETS-1:0] lru_bits;

	tag_t req_tag;
	index_t index;
	offset_t req_offset;
	logic [`CACHE_OFFSET_BITS-2:0] word_sel;

	logic [1:0] load_data;
	logic [1:0] load_dirty;
	line_t hit_line;
	line_t merged_line;
	line_t fill_line;

	assign req_tag = cpu_address[`CACHE_ADDR_WIDTH-1 -: `CACHE_TAG_BITS];
	assign index = cpu_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
	assign req_offset = cpu_address[`CACHE_OFFSET_BITS-1:0];
	assign word_sel = req_offset[`CACHE_OFFSET_BITS-1:1];

	assign load_data = {dp.load_data_2, dp.load_data_1};
	assign load_dirty = {dp.load_dirty_2, dp.load_dirty_1};

	// Tag compare for both ways of the addressed set.
	assign dp.way1_hit = valid_bits[0][index] && (tag_arr[0][index] == req_tag);
	assign dp.way2_hit = valid_bits[1][index] && (tag_arr[1][index] == req_tag);

	assign dp.lru_out = way_t'(lru_bits[index]);
	assign dp.dirty_out = dirty_bits[dp.lru_out][index];

	assign hit_line = dp.way2_hit ? data_arr[1][index] : data_arr[0][index];
	assign cpu_rdata = hit_line[word_sel * `CACHE_WORD_BITS +: `CACHE_WORD_BITS];

	always_comb begin
		merged_line = hit_line;
		for (int b = 0; b < 2; b++) begin
			if (cpu_byte_enable[b]) begin
				merged_line[word_sel * `CACHE_WORD_BITS + b * 8 +: 8] = cpu_wdata[b * 8 +: 8];
			end
		end
	end

	assign fill_line = dp.cpu_src ? merged_line : pmem_rdata;

	// Write-back goes to the victim's own line, a fill to the requested one.
	always_comb begin
		if (dp.wb_addr) begin
			pmem_address = {tag_arr[dp.lru_out][index], index, {`CACHE_OFFSET_BITS{1'b0}}};
		end else begin
			pmem_address = {req_tag, index, {`CACHE_OFFSET_BITS{1'b0}}};
		end
	end

	assign pmem_wdata = data_arr[dp.lru_out][index];

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (load_data[w]) begin
				data_arr[w][index] <= fill_line;
			end
			// A tag rewrite on a write hit stores the same value again.
			if (load_dirty[w]) begin
				tag_arr[w][index] <= req_tag;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lru_bits <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (load_dirty[w]) begin
					valid_bits[w][index] <= 1'b1;
					dirty_bits[w][index] <= dp.dirty_in;
				end
			end
			if (dp.load_lru) begin
				lru_bits[index] <= dp.lru_in;
			end
		end
	end

endmodule : cache_datapath

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
	import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic reset,

	// Processor side.
	input addr_t cpu_address,
	input word_t cpu_wdata,
	input byte_en_t cpu_byte_enable,
	input logic cpu_read,
	input logic cpu_write,
	output word_t cpu_rdata,
	output logic cpu_resp,

	// Physical memory side, one line per transfer.
	output addr_t pmem_address,
	output line_t pmem_wdata,
	input line_t pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp
);

	cache_ctrl_if ctrl_if ();

	cache_control control_i (
		.clk(clk),
		.reset(reset),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.pmem_resp(pmem_resp),
		.cpu_resp(cpu_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.ctrl(ctrl_if.control)
	);

	cache_datapath datapath_i (
		.clk(clk),
		.reset(reset),
		.cpu_address(cpu_address),
		.cpu_wdata(cpu_wdata),
		.cpu_byte_enable(cpu_byte_enable),
		.cpu_rdata(cpu_rdata),
		.pmem_address(pmem_address),
		.pmem_rdata(pmem_rdata),
		.pmem_wdata(pmem_wdata),
		.dp(ctrl_if.datapath)
	);

endmodule : cache_top

`default_nettype wire

/* tests/cache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_model
	import lc3b_mem_pkg::*;
#(
	parameter int resp_delay = 3
)
(
	input logic clk,
	input logic reset,
	input addr_t address,
	input line_t wdata,
	output line_t rdata,
	input logic read,
	input logic write,
	output logic resp
);

	line_t mem [4096];
	int count;

	// Each word starts as its own byte address under a fixed mask.
	initial begin
		for (int l = 0; l < 4096; l++) begin
			for (int w = 0; w < 8; w++) begin
				mem[l][w * 16 +: 16] = {l[11:0], w[2:0], 1'b0} ^ 16'hc3a5;
			end
		end
	end

	assign rdata = mem[address[15:4]];

	always @(posedge clk) begin
		if (reset) begin
			count <= 0;
			resp <= 1'b0;
		end else begin
			resp <= 1'b0;
			if ((read || write) && !resp) begin
				if (count == resp_delay - 1) begin
					resp <= 1'b1;
					count <= 0;
					if (write) begin
						mem[address[15:4]] <= wdata;
					end
				end else begin
					count <= count + 1;
				end
			end
		end
	end

endmodule : cache_mem_model

`default_nettype wire

/* tests/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_tb
	import lc3b_mem_pkg::*;
();

	localparam int clk_period = 100;
	localparam int table_len = 24;
	localparam int mem_delay = 3;

	typedef struct packed {
		logic write;
		addr_t addr;
		word_t wdata;
		byte_en_t be;
	} op_t;

	logic clk;
	logic reset;
	addr_t cpu_address;
	word_t cpu_wdata;
	byte_en_t cpu_byte_enable;
	logic cpu_read;
	logic cpu_write;
	word_t cpu_rdata;
	logic cpu_resp;
	addr_t pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic pmem_read;
	logic pmem_write;
	logic pmem_resp;

	op_t ops [table_len];

	// Shadow of every memory word, plus a software copy of the cache state.
	word_t shadow [32768];
	tag_t m_tag [2][`CACHE_SETS];
	logic m_valid [2][`CACHE_SETS];
	logic m_dirty [2][`CACHE_SETS];
	logic m_lru [`CACHE_SETS];

	int exp_reads = 0;
	int exp_writes = 0;
	int line_reads = 0;
	int line_writes = 0;
	addr_t exp_fill_addr = '0;
	addr_t exp_wb_addr = '0;

	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	cache_top dut_i (
		.clk(clk),
		.reset(reset),
		.cpu_address(cpu_address),
		.cpu_wdata(cpu_wdata),
		.cpu_byte_enable(cpu_byte_enable),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_rdata(cpu_rdata),
		.cpu_resp(cpu_resp),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_resp(pmem_resp)
	);

	cache_mem_model #(.resp_delay(mem_delay)) mem_i (
		.clk(clk),
		.reset(reset),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.rdata(pmem_rdata),
		.read(pmem_read),
		.write(pmem_write),
		.resp(pmem_resp)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic word_t initial_word(input addr_t a);
		return {a[15:1], 1'b0} ^ 16'hc3a5;
	endfunction

	function automatic line_t shadow_line(input addr_t a);
		line_t line;
		for (int w = 0; w < 8; w++) begin
			line[w * 16 +: 16] = shadow[{a[15:4], w[2:0]}];
		end
		return line;
	endfunction

	function automatic op_t make_op(input logic write, input addr_t addr, input byte_en_t be);
		op_t op;
		op.write = write;
		op.addr = addr;
		op.be = be;
		op.wdata = write ? 16'($urandom) : '0;
		return op;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	task automatic check_idle();
		check_value("cpu_resp", 128'(cpu_resp), 128'(0));
		check_value("pmem_read", 128'(pmem_read), 128'(0));
		check_value("pmem_write", 128'(pmem_write), 128'(0));
	endtask

	task automatic reset_model();
		for (int a = 0; a < 32768; a++) begin
			shadow[a] = initial_word(16'(a << 1));
		end
		for (int s = 0; s < `CACHE_SETS; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
				m_tag[w][s] = '0;
			end
		end
	endtask

	task automatic build_table();
		ops[0] = make_op(1'b0, 16'h0094, 2'b00);
		ops[1] = make_op(1'b0, 16'h009e, 2'b00);
		// Partial writes into the line that is already cached.
		ops[2] = make_op(1'b1, 16'h0094, 2'b01);
		ops[3] = make_op(1'b0, 16'h0094, 2'b00);
		ops[4] = make_op(1'b1, 16'h0096, 2'b10);
		ops[5] = make_op(1'b0, 16'h0096, 2'b00);
		// Tags 2 and 3 in set 1 push out the dirty tag 1 line.
		ops[6] = make_op(1'b0, 16'h0112, 2'b00);
		ops[7] = make_op(1'b0, 16'h0190, 2'b00);
		ops[8] = make_op(1'b0, 16'h0094, 2'b00);
		ops[9] = make_op(1'b0, 16'h0112, 2'b00);
		ops[10] = make_op(1'b1, 16'h0354, 2'b11);
		ops[11] = make_op(1'b0, 16'h0354, 2'b00);
		ops[12] = make_op(1'b1, 16'h0210, 2'b11);
		ops[13] = make_op(1'b0, 16'h009a, 2'b00);
		ops[14] = make_op(1'b0, 16'h021e, 2'b00);
		ops[15] = make_op(1'b1, 16'h0398, 2'b11);
		ops[16] = make_op(1'b0, 16'h0214, 2'b00);
		ops[17] = make_op(1'b0, 16'h0110, 2'b00);
		// Set 4 fills both ways with dirty lines, then evicts them in turn.
		ops[18] = make_op(1'b1, 16'h0040, 2'b01);
		ops[19] = make_op(1'b1, 16'h0440, 2'b10);
		ops[20] = make_op(1'b0, 16'h0c40, 2'b00);
		ops[21] = make_op(1'b0, 16'h0040, 2'b00);
		ops[22] = make_op(1'b0, 16'h039c, 2'b00);
		ops[23] = make_op(1'b0, 16'h0398, 2'b00);
	endtask

	// A miss fills the LRU way, then the request hits and moves LRU to the other way.
	task automatic predict(input op_t op, output word_t exp_rdata, output logic exp_hit);
		tag_t tag;
		index_t idx;
		logic [14:0] word_idx;
		logic way;
		tag = op.addr[15:7];
		idx = op.addr[6:4];
		word_idx = op.addr[15:1];
		exp_hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
				exp_hit = 1'b1;
				way = w[0];
			end
		end
		if (!exp_hit) begin
			way = m_lru[idx];
			if (m_valid[way][idx] && m_dirty[way][idx]) begin
				exp_writes++;
				exp_wb_addr = {m_tag[way][idx], idx, 4'h0};
			end
			exp_reads++;
			exp_fill_addr = {tag, idx, 4'h0};
			m_tag[way][idx] = tag;
			m_valid[way][idx] = 1'b1;
			m_dirty[way][idx] = 1'b0;
		end
		if (op.write) begin
			if (op.be[0]) begin
				shadow[word_idx][7:0] = op.wdata[7:0];
			end
			if (op.be[1]) begin
				shadow[word_idx][15:8] = op.wdata[15:8];
			end
			m_dirty[way][idx] = 1'b1;
		end
		m_lru[idx] = ~way;
		exp_rdata = shadow[word_idx];
	endtask

	task automatic apply_op(input op_t op);
		word_t exp_rdata;
		logic exp_hit;
		int cycles;
		@(posedge clk);
		#5;
		cpu_address = op.addr;
		cpu_wdata = op.wdata;
		cpu_byte_enable = op.be;
		cpu_read = ~op.write;
		cpu_write = op.write;
		predict(op, exp_rdata, exp_hit);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!cpu_resp);
		if (!op.write) begin
			check_value("cpu_rdata", 128'(cpu_rdata), 128'(exp_rdata));
		end
		if (exp_hit) begin
			check_value("hit_resp_cycles", 128'(cycles), 128'(1));
		end
		check_value("line_reads", 128'(line_reads), 128'(exp_reads));
		check_value("line_writes", 128'(line_writes), 128'(exp_writes));
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			assert (!(pmem_read && pmem_write)) else begin
				other_errors++;
				$display("memory read and write were requested together at %0t ns", $time);
			end
			if (pmem_resp && pmem_read) begin
				line_reads++;
				check_value("pmem_address", 128'(pmem_address), 128'(exp_fill_addr));
			end
			if (pmem_resp && pmem_write) begin
				line_writes++;
				check_value("pmem_address", 128'(pmem_address), 128'(exp_wb_addr));
				check_value("pmem_wdata", pmem_wdata, shadow_line(exp_wb_addr));
			end
		end
	end

	initial begin
		#(table_len * 40 * clk_period);
		$display("watchdog expired after %0d cycles without finishing the table",
			table_len * 40);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		cpu_address = '0;
		cpu_wdata = '0;
		cpu_byte_enable = '0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		void'($urandom(32'h3af7));
		reset_model();
		build_table();

		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#5;
			check_idle();
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle();

		for (int i = 0; i < table_len; i++) begin
			apply_op(ops[i]);
		end
		@(posedge clk);
		#5;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		repeat (2) @(posedge clk);

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule : cache_tb

`default_nettype wire

/* cache_top.f */
+incdir+rtl
rtl/lc3b_mem_pkg.sv
rtl/cache_pkg.sv
rtl/cache_ctrl_if.sv
rtl/cache_control.sv
rtl/cache_datapath.sv
rtl/cache_top.sv
tests/cache_mem_model.sv
tests/cache_tb.sv

/* Makefile */
TOP = cache_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cache_top.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	verilator --binary --timing --assert -f cache_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f cache_top.f --top-module cache_top

clean:
	rm -rf obj_dir sim.log
